// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // raw instruction word as returned by the bus
    typedef logic [31:0] instr_t;

    // boot rom entry point
    localparam addr_t RESET_PC_DEFAULT = 32'hBFC0_0000;

    // one instruction per fetch
    localparam addr_t PC_STEP = 32'd4;

    // predictor size, power of two
    localparam int BTB_ENTRIES_DEFAULT = 16;

    // fetch sequencer states
    // idle: pc settles, redirects are taken here or a read is launched
    // bus: one wishbone read outstanding
    typedef enum logic {
        SEQ_IDLE,
        SEQ_BUS
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/redirect_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module redirect_latch (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             i_redirect_valid,
    input  fetch_pkg::addr_t      i_redirect_pc,
    input  wire logic             i_redirect_taken,
    output logic                  o_pending_valid,
    output fetch_pkg::addr_t      o_pending_pc
);
    import fetch_pkg::*;

    // redirect parked while a bus read is still out
    logic  saved_valid_q;
    addr_t saved_pc_q;

    // newest redirect wins, no cycle lost on the way in
    assign o_pending_valid = i_redirect_valid || saved_valid_q;
    assign o_pending_pc    = i_redirect_valid ? i_redirect_pc : saved_pc_q;

    // valid flag, the only state that needs a defined start
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_valid_q <= 1'b0;
        end else if (i_redirect_valid) begin
            // a fresh redirect always survives the take in the same cycle
            saved_valid_q <= 1'b1;
        end else if (i_redirect_taken) begin
            saved_valid_q <= 1'b0;
        end
    end

    // target address
    always_ff @(posedge clk) begin
        if (i_redirect_valid) begin
            saved_pc_q <= i_redirect_pc;
        end
    end

    // sequencer may only consume what this latch is offering
    a_taken_needs_pending : assert property (@(posedge clk) disable iff (reset)
        i_redirect_taken |-> o_pending_valid);

endmodule

`default_nettype wire

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
    input  wire logic             clk,
    input  wire logic             reset,
    // lookup side, combinational
    input  fetch_pkg::addr_t      i_lookup_pc,
    output logic                  o_pred_hit,
    output fetch_pkg::addr_t      o_pred_target,
    // training side from execute
    input  wire logic             i_update_valid,
    input  fetch_pkg::addr_t      i_update_pc,
    input  wire logic             i_update_taken,
    input  fetch_pkg::addr_t      i_update_target
);
    import fetch_pkg::*;

    // index sits right above the byte offset
    localparam int IDX_W  = $clog2(BTB_ENTRIES);
    localparam int IDX_LO = 2;
    localparam int IDX_HI = IDX_LO + IDX_W - 1;
    // everything above the index is tag
    localparam int TAG_W  = $bits(addr_t) - IDX_W - IDX_LO;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    // per-entry state
    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q    [BTB_ENTRIES];
    addr_t                  target_q [BTB_ENTRIES];

    btb_idx_t lookup_idx;
    btb_tag_t lookup_tag;
    btb_idx_t update_idx;
    btb_tag_t update_tag;
    logic     update_match;

    // address split
    assign lookup_idx = i_lookup_pc[IDX_HI:IDX_LO];
    assign lookup_tag = i_lookup_pc[$bits(addr_t)-1:IDX_HI+1];
    assign update_idx = i_update_pc[IDX_HI:IDX_LO];
    assign update_tag = i_update_pc[$bits(addr_t)-1:IDX_HI+1];

    // hit needs valid plus full tag compare, aliases miss
    assign o_pred_hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign o_pred_target = target_q[lookup_idx];

    // not-taken only evicts its own branch, not an alias
    assign update_match = (tag_q[update_idx] == update_tag);

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (i_update_valid) begin
            if (i_update_taken) begin
                valid_q[update_idx] <= 1'b1;
            end else if (update_match) begin
                valid_q[update_idx] <= 1'b0;
            end
        end
    end

    // tag and target, written only by taken branches
    always_ff @(posedge clk) begin
        if (i_update_valid && i_update_taken) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= i_update_target;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter fetch_pkg::addr_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
    input  wire logic             clk,
    input  wire logic             reset,
    // pending redirect from the latch
    input  wire logic             i_pending_valid,
    input  fetch_pkg::addr_t      i_pending_pc,
    output logic                  o_redirect_taken,
    // btb lookup
    output fetch_pkg::addr_t      o_lookup_pc,
    input  wire logic             i_pred_hit,
    input  fetch_pkg::addr_t      i_pred_target,
    // wishbone classic read master
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output fetch_pkg::addr_t      o_wb_adr,
    input  fetch_pkg::instr_t     i_wb_dat,
    input  wire logic             i_wb_ack,
    // push toward the fetch buffer
    input  wire logic             i_can_accept,
    output logic                  o_push_valid,
    output fetch_pkg::addr_t      o_push_pc,
    output fetch_pkg::instr_t     o_push_instr,
    output logic                  o_push_pred_taken,
    output fetch_pkg::addr_t      o_push_pred_pc
);
    import fetch_pkg::*;

    seq_state_t state_q;
    addr_t      pc_q;

    // prediction frozen at bus start, travels with the word
    logic  pred_taken_q;
    addr_t pred_pc_q;

    addr_t seq_pc;
    logic  in_bus;
    logic  bus_start;
    logic  bus_done;

    assign seq_pc = pc_q + PC_STEP;
    assign in_bus = (state_q == SEQ_BUS);

    // launch only when idle, nothing pending and the buffer has room
    assign bus_start = (state_q == SEQ_IDLE) && !i_pending_valid && i_can_accept;
    assign bus_done  = in_bus && i_wb_ack;

    // btb always looks at the current pc
    assign o_lookup_pc = pc_q;

    // cyc and stb move together, adr is the pc itself so it cannot slip
    assign o_wb_cyc = in_bus;
    assign o_wb_stb = in_bus;
    assign o_wb_adr = pc_q;

    // redirect consumed when idle or when the outstanding read retires
    assign o_redirect_taken = i_pending_valid && ((state_q == SEQ_IDLE) || bus_done);

    // wrong-path word dropped whenever a redirect is pending
    assign o_push_valid      = bus_done && !i_pending_valid;
    assign o_push_pc         = pc_q;
    assign o_push_instr      = i_wb_dat;
    assign o_push_pred_taken = pred_taken_q;
    assign o_push_pred_pc    = pred_pc_q;

    // fsm and pc register
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= SEQ_IDLE;
            pc_q    <= RESET_PC;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (i_pending_valid) begin
                        // bus at the new pc starts one cycle later
                        pc_q <= i_pending_pc;
                    end else if (i_can_accept) begin
                        state_q <= SEQ_BUS;
                    end
                end
                SEQ_BUS: begin
                    // hold pc until ack, redirect waits in the latch
                    if (i_wb_ack) begin
                        state_q <= SEQ_IDLE;
                        if (i_pending_valid) begin
                            pc_q <= i_pending_pc;
                        end else begin
                            pc_q <= pred_pc_q;
                        end
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // predicted next pc, btb target on hit else sequential
    always_ff @(posedge clk) begin
        if (bus_start) begin
            pred_taken_q <= i_pred_hit;
            pred_pc_q    <= i_pred_hit ? i_pred_target : seq_pc;
        end
    end

    // classic handshake, request held steady until the slave answers
    a_adr_stable : assert property (@(posedge clk) disable iff (reset)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr));

    // slave acks only inside a cycle, pushes only on that ack
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (reset)
        i_wb_ack |-> o_wb_cyc);
    a_push_on_ack : assert property (@(posedge clk) disable iff (reset)
        o_push_valid |-> i_wb_ack);

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             i_flush,
    // from the sequencer
    input  wire logic             i_push_valid,
    input  fetch_pkg::addr_t      i_push_pc,
    input  fetch_pkg::instr_t     i_push_instr,
    input  wire logic             i_push_pred_taken,
    input  fetch_pkg::addr_t      i_push_pred_pc,
    output logic                  o_can_accept,
    // toward decode
    output logic                  o_fetch_valid,
    output fetch_pkg::addr_t      o_fetch_pc,
    output fetch_pkg::instr_t     o_fetch_instr,
    output logic                  o_fetch_pred_taken,
    output fetch_pkg::addr_t      o_fetch_pred_pc,
    input  wire logic             i_fetch_ready
);
    import fetch_pkg::*;

    typedef logic [1:0] fb_count_t;

    // two slots, ring order
    addr_t  pc_q         [2];
    instr_t instr_q      [2];
    logic   pred_taken_q [2];
    addr_t  pred_pc_q    [2];

    logic      wr_ptr_q;
    logic      rd_ptr_q;
    fb_count_t count_q;

    logic full;
    logic do_push;
    logic do_pop;

    assign full = (count_q == 2'd2);
    // sampled only while the sequencer is idle, so no read is out
    assign o_can_accept = !full;

    // head of queue drives decode directly
    assign o_fetch_valid      = (count_q != 2'd0);
    assign o_fetch_pc         = pc_q[rd_ptr_q];
    assign o_fetch_instr      = instr_q[rd_ptr_q];
    assign o_fetch_pred_taken = pred_taken_q[rd_ptr_q];
    assign o_fetch_pred_pc    = pred_pc_q[rd_ptr_q];

    // flush beats a push in the same cycle
    assign do_push = i_push_valid && !i_flush;
    assign do_pop  = o_fetch_valid && i_fetch_ready;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (do_pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_q[wr_ptr_q]         <= i_push_pc;
            instr_q[wr_ptr_q]      <= i_push_instr;
            pred_taken_q[wr_ptr_q] <= i_push_pred_taken;
            pred_pc_q[wr_ptr_q]    <= i_push_pred_pc;
        end
    end

    // sequencer gating keeps a slot free for every read in flight
    a_no_push_full : assert property (@(posedge clk) disable iff (reset)
        i_push_valid |-> !full);

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter fetch_pkg::addr_t RESET_PC    = fetch_pkg::RESET_PC_DEFAULT,
    parameter int               BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
    input  wire logic             clk,
    input  wire logic             reset,
    // redirect from execute
    input  wire logic             i_redirect_valid,
    input  fetch_pkg::addr_t      i_redirect_pc,
    // btb training from execute
    input  wire logic             i_update_valid,
    input  fetch_pkg::addr_t      i_update_pc,
    input  wire logic             i_update_taken,
    input  fetch_pkg::addr_t      i_update_target,
    // instruction memory, wishbone classic
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output fetch_pkg::addr_t      o_wb_adr,
    input  fetch_pkg::instr_t     i_wb_dat,
    input  wire logic             i_wb_ack,
    // packets to decode
    output logic                  o_fetch_valid,
    output fetch_pkg::addr_t      o_fetch_pc,
    output fetch_pkg::instr_t     o_fetch_instr,
    output logic                  o_fetch_pred_taken,
    output fetch_pkg::addr_t      o_fetch_pred_pc,
    input  wire logic             i_fetch_ready
);
    import fetch_pkg::*;

    // latch to sequencer
    logic   pending_valid;
    addr_t  pending_pc;
    logic   redirect_taken;

    // sequencer to btb
    addr_t  lookup_pc;
    logic   pred_hit;
    addr_t  pred_target;

    // sequencer to buffer
    logic   push_valid;
    addr_t  push_pc;
    instr_t push_instr;
    logic   push_pred_taken;
    addr_t  push_pred_pc;
    logic   can_accept;

    redirect_latch u_redirect_latch (
        .clk              (clk),
        .reset            (reset),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .i_redirect_taken (redirect_taken),
        .o_pending_valid  (pending_valid),
        .o_pending_pc     (pending_pc)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk             (clk),
        .reset           (reset),
        .i_lookup_pc     (lookup_pc),
        .o_pred_hit      (pred_hit),
        .o_pred_target   (pred_target),
        .i_update_valid  (i_update_valid),
        .i_update_pc     (i_update_pc),
        .i_update_taken  (i_update_taken),
        .i_update_target (i_update_target)
    );

    fetch_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_fetch_sequencer (
        .clk               (clk),
        .reset             (reset),
        .i_pending_valid   (pending_valid),
        .i_pending_pc      (pending_pc),
        .o_redirect_taken  (redirect_taken),
        .o_lookup_pc       (lookup_pc),
        .i_pred_hit        (pred_hit),
        .i_pred_target     (pred_target),
        .o_wb_cyc          (o_wb_cyc),
        .o_wb_stb          (o_wb_stb),
        .o_wb_adr          (o_wb_adr),
        .i_wb_dat          (i_wb_dat),
        .i_wb_ack          (i_wb_ack),
        .i_can_accept      (can_accept),
        .o_push_valid      (push_valid),
        .o_push_pc         (push_pc),
        .o_push_instr      (push_instr),
        .o_push_pred_taken (push_pred_taken),
        .o_push_pred_pc    (push_pred_pc)
    );

    // redirect empties queued wrong-path packets
    fetch_buffer u_fetch_buffer (
        .clk                (clk),
        .reset              (reset),
        .i_flush            (i_redirect_valid),
        .i_push_valid       (push_valid),
        .i_push_pc          (push_pc),
        .i_push_instr       (push_instr),
        .i_push_pred_taken  (push_pred_taken),
        .i_push_pred_pc     (push_pred_pc),
        .o_can_accept       (can_accept),
        .o_fetch_valid      (o_fetch_valid),
        .o_fetch_pc         (o_fetch_pc),
        .o_fetch_instr      (o_fetch_instr),
        .o_fetch_pred_taken (o_fetch_pred_taken),
        .o_fetch_pred_pc    (o_fetch_pred_pc),
        .i_fetch_ready      (i_fetch_ready)
    );

endmodule

`default_nettype wire

// ==== tests/instr_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem_model (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             i_wb_cyc,
    input  wire logic             i_wb_stb,
    input  fetch_pkg::addr_t      i_wb_adr,
    output fetch_pkg::instr_t     o_wb_dat,
    output logic                  o_wb_ack,
    // wait states for the next read, picked up when it starts
    input  wire logic [1:0]       i_wait_states
);
    import fetch_pkg::*;

    logic       busy_q;
    logic [1:0] wait_q;

    // every word is its own address scrambled, so each address is unique
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= i_wait_states;
                end else if (wait_q == 2'd0) begin
                    busy_q   <= 1'b0;
                    o_wb_ack <= 1'b1;
                    o_wb_dat <= i_wb_adr ^ 32'hA5A5_A5A5;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/fetch_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam addr_t       RESET_PC    = RESET_PC_DEFAULT;
    localparam int          BTB_ENTRIES = 16;
    localparam int          IDX_BITS    = $clog2(BTB_ENTRIES);
    localparam logic [31:0] MEM_KEY     = 32'hA5A5_A5A5;
    localparam addr_t       BR_PC       = 32'h0000_2000;
    localparam addr_t       BR_TARGET   = 32'h0000_3000;

    logic       clk;
    logic       reset;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       update_valid;
    addr_t      update_pc;
    logic       update_taken;
    addr_t      update_target;
    logic       wb_cyc;
    logic       wb_stb;
    addr_t      wb_adr;
    instr_t     wb_dat;
    logic       wb_ack;
    logic       fetch_valid;
    addr_t      fetch_pc;
    instr_t     fetch_instr;
    logic       fetch_pred_taken;
    addr_t      fetch_pred_pc;
    logic       fetch_ready;
    logic [1:0] wait_states;

    // scoreboard and model state
    logic [31:0] lcg_state;
    logic        ready_random;
    logic        timed_out;
    int          error_count;
    int          rx_count;
    int          pred_seen;
    addr_t       exp_pc;
    logic        hold_valid;
    logic [96:0] held_packet;
    logic        model_valid  [BTB_ENTRIES];
    addr_t       model_tag    [BTB_ENTRIES];
    addr_t       model_target [BTB_ENTRIES];

    fetch_frontend #(
        .RESET_PC    (RESET_PC),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) UUT (
        .clk (clk), .reset (reset),
        .i_redirect_valid (redirect_valid), .i_redirect_pc (redirect_pc),
        .i_update_valid (update_valid), .i_update_pc (update_pc),
        .i_update_taken (update_taken), .i_update_target (update_target),
        .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr),
        .i_wb_dat (wb_dat), .i_wb_ack (wb_ack),
        .o_fetch_valid (fetch_valid), .o_fetch_pc (fetch_pc), .o_fetch_instr (fetch_instr),
        .o_fetch_pred_taken (fetch_pred_taken), .o_fetch_pred_pc (fetch_pred_pc),
        .i_fetch_ready (fetch_ready)
    );

    instr_mem_model u_mem (
        .clk (clk), .reset (reset), .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb),
        .i_wb_adr (wb_adr), .o_wb_dat (wb_dat), .o_wb_ack (wb_ack),
        .i_wait_states (wait_states)
    );

    always #4 clk = !clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected packet at pc, {pc, word, pred_taken, next pc}
    function automatic logic [96:0] expected_packet(input addr_t pc);
        int   idx;
        logic hit;
        idx = (pc >> 2) % BTB_ENTRIES;
        hit = model_valid[idx] && (model_tag[idx] == (pc >> (2 + IDX_BITS)));
        return {pc, pc ^ MEM_KEY, hit, hit ? model_target[idx] : pc + 32'd4};
    endfunction

    // comparator, everything sampled at the rising edge
    always @(posedge clk) begin : compare_packets
        logic [96:0] exp_pkt;
        logic [96:0] got_pkt;
        int          idx;
        got_pkt = {fetch_pc, fetch_instr, fetch_pred_taken, fetch_pred_pc};
        if (reset) begin
            exp_pc = RESET_PC;
            hold_valid = 1'b0;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                model_valid[i] = 1'b0;
            end
        end else begin
            // stalled packet must not move
            if (hold_valid) begin
                assert (fetch_valid && got_pkt == held_packet) else begin
                    $display("Mismatch at %0t: packet changed while stalled", $time);
                    error_count++;
                end
            end
            if (fetch_valid && fetch_ready) begin
                exp_pkt = expected_packet(exp_pc);
                assert (fetch_pc == exp_pkt[96:65]) else begin
                    $display("Mismatch at %0t: pc %h, expected %h", $time, fetch_pc,
                             exp_pkt[96:65]);
                    error_count++;
                end
                assert (fetch_instr == exp_pkt[64:33]) else begin
                    $display("Mismatch at %0t: instr %h, expected %h", $time, fetch_instr,
                             exp_pkt[64:33]);
                    error_count++;
                end
                assert (fetch_pred_taken == exp_pkt[32]) else begin
                    $display("Mismatch at %0t: pred_taken %b at pc %h", $time,
                             fetch_pred_taken, fetch_pc);
                    error_count++;
                end
                assert (fetch_pred_pc == exp_pkt[31:0]) else begin
                    $display("Mismatch at %0t: pred_pc %h, expected %h", $time,
                             fetch_pred_pc, exp_pkt[31:0]);
                    error_count++;
                end
                rx_count++;
                pred_seen += fetch_pred_taken;
                exp_pc = exp_pkt[31:0];
            end
            // flush drops the stalled packet legally
            hold_valid  = fetch_valid && !fetch_ready && !redirect_valid;
            held_packet = got_pkt;
            if (update_valid) begin
                idx = (update_pc >> 2) % BTB_ENTRIES;
                if (update_taken) begin
                    model_valid[idx]  = 1'b1;
                    model_tag[idx]    = update_pc >> (2 + IDX_BITS);
                    model_target[idx] = update_target;
                end else if (model_tag[idx] == (update_pc >> (2 + IDX_BITS))) begin
                    model_valid[idx] = 1'b0;
                end
            end
            // packets after the redirect cycle restart at its target
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
        end
    end

    // one clock, inputs change 1 ns after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
        lcg_state      = lcg_next(lcg_state);
        wait_states    = lcg_state[17:16];
        fetch_ready    = ready_random ? (lcg_state[21] || lcg_state[26]) : 1'b1;
        redirect_valid = 1'b0;
        update_valid   = 1'b0;
    endtask

    task automatic wait_packets(input int n, input string what);
        int target;
        int cycles;
        target = rx_count + n;
        cycles = 0;
        while (!timed_out && rx_count < target) begin
            if (cycles > 20 * n + 20) begin
                $display("Error: no packet progress, timed out waiting for %s", what);
                timed_out = 1'b1;
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    task automatic wait_bus_request();
        int cycles;
        cycles = 0;
        while (!timed_out && !wb_stb) begin
            if (cycles > 50) begin
                $display("Error: the bus never started a read, timed out");
                timed_out = 1'b1;
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    // training and redirect in the same cycle, held until the next edge
    task automatic train_and_redirect(input logic train, input logic taken,
                                      input addr_t target, input addr_t dest);
        update_valid   = train;
        update_pc      = BR_PC;
        update_taken   = taken;
        update_target  = target;
        redirect_valid = 1'b1;
        redirect_pc    = dest;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (error_count == errs_before && !timed_out) begin
            $display("test %0d %s: ok, %0d packets so far", num, name, rx_count);
        end else begin
            $display("test %0d %s: bad, %0d errors", num, name, error_count - errs_before);
        end
    endtask

    initial begin : run_tests
        int    errs;
        int    preds;
        addr_t dest;
        clk = 1'b0;
        reset = 1'b1;
        {redirect_valid, update_valid, update_taken} = 3'b000;
        redirect_pc = '0;
        update_pc = '0;
        update_target = '0;
        fetch_ready = 1'b1;
        wait_states = 2'd0;
        lcg_state = 32'h9d6ee2e4;
        {ready_random, timed_out} = 2'b00;
        {error_count, rx_count, pred_seen} = {32'd0, 32'd0, 32'd0};
        repeat (5) step_cycle();
        assert (!wb_cyc && !wb_stb && !fetch_valid) else begin
            $display("Mismatch at %0t: bus or fetch output active in reset", $time);
            error_count++;
        end
        reset = 1'b0;

        // sequential stream from the reset vector
        errs = error_count;
        step_cycle();
        assert (wb_stb && wb_adr == RESET_PC) else begin
            $display("Mismatch at %0t: first read not at reset pc", $time);
            error_count++;
        end
        wait_packets(8, "sequential packets");
        report_test(1, "sequential fetch", errs);

        errs = error_count;
        ready_random = 1'b1;
        wait_packets(40, "packets under back-pressure");
        report_test(2, "back-pressure", errs);

        // even rounds hit an open bus cycle, odd ones a random gap
        errs = error_count;
        for (int k = 0; k < 6; k++) begin
            if (k % 2 == 0) begin
                wait_bus_request();
            end else begin
                repeat (lcg_state[2:0]) step_cycle();
            end
            dest = 32'h0001_0000 | (lcg_state & 32'h0000_0FFC);
            train_and_redirect(1'b0, 1'b0, '0, dest);
            wait_packets(6, "packets after redirect");
        end
        report_test(3, "redirect", errs);

        errs = error_count;
        preds = pred_seen;
        train_and_redirect(1'b1, 1'b1, BR_TARGET, BR_PC);
        wait_packets(4, "packets after trained redirect");
        assert (pred_seen > preds) else begin
            $display("Mismatch at %0t: trained branch was not predicted", $time);
            error_count++;
        end
        report_test(4, "trained prediction", errs);

        // untrain, then retrain and fetch an alias of the same index
        errs = error_count;
        preds = pred_seen;
        train_and_redirect(1'b1, 1'b0, '0, BR_PC);
        wait_packets(4, "packets after untraining");
        step_cycle();
        train_and_redirect(1'b1, 1'b1, BR_TARGET, BR_PC + BTB_ENTRIES * 4);
        wait_packets(4, "packets at the alias");
        assert (pred_seen == preds) else begin
            $display("Mismatch at %0t: untrained or aliased pc was predicted", $time);
            error_count++;
        end
        report_test(5, "untraining and aliasing", errs);

        $display("packets %0d, predicted %0d, errors %0d", rx_count, pred_seen, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_frontend.f ====
source/fetch_pkg.sv
source/redirect_latch.sv
source/branch_target_buffer.sv
source/fetch_sequencer.sv
source/fetch_buffer.sv
source/fetch_frontend.sv
tests/instr_mem_model.sv
tests/fetch_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - source/fetch_pkg.sv
      - source/redirect_latch.sv
      - source/branch_target_buffer.sv
      - source/fetch_sequencer.sv
      - source/fetch_buffer.sv
      - source/fetch_frontend.sv
  - target: test
    files:
      - tests/instr_mem_model.sv
      - tests/fetch_frontend_tb.sv
